// File: hdl/issue_pkg.sv
package issue_pkg;

  // ------------------------------------------------------------------
  // Operation and instruction words
  // ------------------------------------------------------------------

  typedef struct packed {
    logic       rden1;   // Reads raddr1.
    logic       rden2;   // Reads raddr2, else immediate operand.
    logic       wren;    // Writes waddr.
    logic       load;
    logic       store;
    logic       alu;
    logic       crden;   // CSR read, old value retires.
    logic       cwren;   // CSR write with operand 1.
    logic [2:0] alu_fn;
  } operation_type;

  typedef struct packed {
    logic          valid;
    operation_type op;
    logic [4:0]    waddr;
    logic [4:0]    raddr1;
    logic [4:0]    raddr2;
    logic [11:0]   imm;      // Sign extended in execute.
    logic [11:0]   caddr;
  } instruction_type;

  // ------------------------------------------------------------------
  // Pipeline interfaces
  // ------------------------------------------------------------------

  typedef struct packed {
    logic       rden1;
    logic       rden2;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
  } register_read_type;

  typedef struct packed {
    logic        crden;
    logic [11:0] craddr;
  } csr_read_type;

  typedef struct packed {
    logic       load;
    logic       cwren;
    logic [4:0] waddr;
  } stage_status_type;

  typedef struct packed {
    instruction_type inst;
    logic [31:0]     cdata;   // CSR value read at issue.
  } issued_type;

  typedef struct packed {
    logic        valid;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } retire_type;

  // ------------------------------------------------------------------
  // Constants
  // ------------------------------------------------------------------

  localparam logic [11:0] csr_mscratch  = 12'h340;
  localparam logic [11:0] csr_mcycle_lo = 12'hB00;

  localparam logic [2:0] alu_add  = 3'd0;
  localparam logic [2:0] alu_sub  = 3'd1;
  localparam logic [2:0] alu_and  = 3'd2;
  localparam logic [2:0] alu_or   = 3'd3;
  localparam logic [2:0] alu_xor  = 3'd4;
  localparam logic [2:0] alu_sll  = 3'd5;
  localparam logic [2:0] alu_slt  = 3'd6;
  localparam logic [2:0] alu_pass = 3'd7;   // Immediate only.

  localparam instruction_type init_instruction = '0;

endpackage

// File: hdl/pair_hazard_unit.sv
`timescale 1ns/1ns

module pair_hazard_unit import issue_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            flush,
  input  logic            stall,
  input  logic            pair_valid,
  input  instruction_type slot0,
  input  instruction_type slot1,
  output instruction_type calc0,
  output instruction_type calc1,
  output logic            split_hold
);

  logic            pending;   // Second half still to issue.
  logic            dependent;
  logic            mem_conflict;
  logic            csr_conflict;
  logic            split;
  instruction_type first;
  instruction_type second;

  assign first  = slot0.valid ? slot0 : init_instruction;
  assign second = slot1.valid ? slot1 : init_instruction;

  // slot1 needs the result of slot0.
  assign dependent = first.op.wren && (first.waddr != 5'd0) &&
                     ((second.op.rden1 && second.raddr1 == first.waddr) ||
                      (second.op.rden2 && second.raddr2 == first.waddr));

  assign mem_conflict = (first.op.load | first.op.store) &
                        (second.op.load | second.op.store);
  assign csr_conflict = second.op.crden | second.op.cwren;

  assign split = pair_valid & first.valid & second.valid &
                 (dependent | mem_conflict | csr_conflict);

  always_comb begin
    calc0      = init_instruction;
    calc1      = init_instruction;
    split_hold = 1'b0;
    if (pair_valid) begin
      if (pending) begin
        calc0 = second;   // Second half alone.
      end else if (split) begin
        calc0      = first;
        split_hold = ~flush;
      end else begin
        calc0 = first;
        calc1 = second;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
    end else if (flush) begin
      pending <= 1'b0;
    end else if (!stall) begin
      pending <= split & ~pending;
    end
  end

  // The source keeps the split pair while its second half waits.
  a_pair_held_while_pending: assert property (
    @(posedge clock) disable iff (!reset) pending |-> (pair_valid && $stable(slot1))
  );

endmodule

// File: hdl/issue_stage.sv
`timescale 1ns/1ns

module issue_stage import issue_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  instruction_type         calc0,
  input  instruction_type         calc1,
  input  logic                    split_hold,
  input  stage_status_type [1:0]  e_status,
  input  stage_status_type [1:0]  m_status,
  input  logic [31:0]             cdata,
  output register_read_type       read0,
  output register_read_type       read1,
  output csr_read_type            csr_rd,
  output issued_type [1:0]        issued,
  output logic                    stall,
  output logic                    hold
);

  instruction_type [1:0] calc;
  issued_type [1:0]      issue_next;
  logic                  load_use;
  logic                  csr_busy;
  logic                  issued_load_use;

  function automatic logic reads_reg(input instruction_type inst, input logic [4:0] addr);
    return (inst.op.rden1 && inst.raddr1 == addr) ||
           (inst.op.rden2 && inst.raddr2 == addr);
  endfunction

  assign calc = {calc1, calc0};

  // ------------------------------------------------------------------
  // Hazard detection
  // ------------------------------------------------------------------

  always_comb begin
    load_use = 1'b0;
    csr_busy = 1'b0;
    for (int e = 0; e < 2; e++) begin
      csr_busy = csr_busy | e_status[e].cwren | m_status[e].cwren;
      for (int s = 0; s < 2; s++) begin
        if (e_status[e].load && calc[s].valid && reads_reg(calc[s], e_status[e].waddr)) begin
          load_use = 1'b1;   // Load data only exists in w.
        end
      end
    end
  end

  assign stall = (load_use | csr_busy) & ~flush;
  assign hold  = split_hold | stall;

  // ------------------------------------------------------------------
  // Read requests from the unregistered pair
  // ------------------------------------------------------------------

  assign read0 = '{rden1: calc0.op.rden1, rden2: calc0.op.rden2,
                   raddr1: calc0.raddr1, raddr2: calc0.raddr2};
  assign read1 = '{rden1: calc1.op.rden1, rden2: calc1.op.rden2,
                   raddr1: calc1.raddr1, raddr2: calc1.raddr2};

  assign csr_rd.crden  = calc0.op.crden | calc1.op.crden;
  assign csr_rd.craddr = calc0.op.crden ? calc0.caddr : calc1.caddr;   // Slot0 first.

  // ------------------------------------------------------------------
  // Issue register
  // ------------------------------------------------------------------

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      issue_next[s].inst  = calc[s];
      issue_next[s].cdata = calc[s].op.crden ? cdata : 32'd0;
    end
    if (stall || flush) begin
      issue_next = '0;   // Bubble pair.
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      issued <= '0;
    end else begin
      issued <= issue_next;
    end
  end

  // An issued slot never reads a load that is only one stage ahead.
  always_comb begin
    issued_load_use = 1'b0;
    for (int k = 0; k < 2; k++) begin
      for (int s = 0; s < 2; s++) begin
        if (m_status[k].load && reads_reg(issued[s].inst, m_status[k].waddr)) begin
          issued_load_use = 1'b1;
        end
      end
    end
  end

  a_no_load_use_in_e: assert property (
    @(posedge clock) disable iff (!reset) !issued_load_use
  );

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ns

module register_file import issue_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  register_read_type read0,
  input  register_read_type read1,
  output logic [31:0]       rdata0_1,
  output logic [31:0]       rdata0_2,
  output logic [31:0]       rdata1_1,
  output logic [31:0]       rdata1_2,
  input  retire_type        write0,
  input  retire_type        write1
);

  logic [31:0] regs [32];

  // Write data of this cycle passes straight to the read.
  function automatic logic [31:0] read_word(input logic en, input logic [4:0] addr);
    if (!en || addr == 5'd0) return 32'd0;
    if (write1.valid && write1.waddr == addr) return write1.wdata;
    if (write0.valid && write0.waddr == addr) return write0.wdata;
    return regs[addr];
  endfunction

  always_ff @(posedge clock) begin
    rdata0_1 <= read_word(read0.rden1, read0.raddr1);
    rdata0_2 <= read_word(read0.rden2, read0.raddr2);
    rdata1_1 <= read_word(read1.rden1, read1.raddr1);
    rdata1_2 <= read_word(read1.rden2, read1.raddr2);
  end

  always_ff @(posedge clock) begin
    if (write0.valid) regs[write0.waddr] <= write0.wdata;
    if (write1.valid) regs[write1.waddr] <= write1.wdata;   // Slot1 is younger.
  end

  a_no_x0_write: assert property (
    @(posedge clock) disable iff (!reset)
      !(write0.valid && write0.waddr == 5'd0) && !(write1.valid && write1.waddr == 5'd0)
  );

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/1ns

module csr_file import issue_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  csr_read_type csr_rd,
  output logic [31:0]  cdata,
  input  logic         cwren,
  input  logic [11:0]  caddr,
  input  logic [31:0]  cwdata
);

  logic [31:0] mscratch;
  logic [31:0] mcycle_lo;

  always_comb begin
    cdata = 32'd0;
    if (csr_rd.crden) begin
      case (csr_rd.craddr)
        csr_mscratch:  cdata = mscratch;
        csr_mcycle_lo: cdata = mcycle_lo;
        default:       cdata = 32'd0;   // Unimplemented.
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mscratch  <= 32'd0;
      mcycle_lo <= 32'd0;
    end else begin
      mcycle_lo <= mcycle_lo + 32'd1;   // Read only.
      if (cwren && caddr == csr_mscratch) begin
        mscratch <= cwdata;
      end
    end
  end

endmodule

// File: hdl/execute_pipe.sv
`timescale 1ns/1ns

module execute_pipe import issue_pkg::*; #(
  parameter int DMEM_DEPTH = 16
) (
  input  logic                   clock,
  input  logic                   reset,
  input  issued_type [1:0]       issued,
  input  logic [31:0]            rdata0_1,
  input  logic [31:0]            rdata0_2,
  input  logic [31:0]            rdata1_1,
  input  logic [31:0]            rdata1_2,
  output stage_status_type [1:0] e_status,
  output stage_status_type [1:0] m_status,
  output logic                   cwren,
  output logic [11:0]            caddr,
  output logic [31:0]            cwdata,
  output retire_type             retire0,
  output retire_type             retire1
);

  localparam int DMEM_AW = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

  logic [1:0][31:0]      file_rs1, file_rs2, e_rs1, e_rs2, e_imm, e_result;
  logic [1:0]            e_mem;
  logic                  mem_slot;
  logic [31:0]           e_addr;
  instruction_type [1:0] m_inst;
  logic [1:0][31:0]      m_result, m_rs1;
  logic                  m_load, m_store;
  logic [DMEM_AW-1:0]    m_addr;
  logic [31:0]           m_wdata;
  logic [31:0]           dmem [DMEM_DEPTH];
  logic [31:0]           load_data;
  logic [1:0]            w_valid, w_load;
  logic [1:0][4:0]       w_waddr;
  logic [1:0][31:0]      w_result;
  retire_type [1:0]      w_out;

  function automatic logic [31:0] alu(input logic [2:0] fn, input logic [31:0] a,
                                      input logic [31:0] b, input logic [31:0] imm);
    case (fn)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      alu_or:  return a | b;
      alu_xor: return a ^ b;
      alu_sll: return a << b[4:0];
      alu_slt: return {31'd0, $signed(a) < $signed(b)};
      default: return imm;
    endcase
  endfunction

  // Youngest producer wins; loads in m have no data yet.
  function automatic logic [31:0] forward(input logic [4:0] addr, input logic [31:0] file_data);
    if (addr == 5'd0) return 32'd0;
    for (int s = 1; s >= 0; s--) begin
      if (m_inst[s].op.wren && !m_inst[s].op.load && m_inst[s].waddr == addr) return m_result[s];
    end
    for (int s = 1; s >= 0; s--) begin
      if (w_out[s].valid && w_out[s].waddr == addr) return w_out[s].wdata;
    end
    return file_data;
  endfunction

  // ------------------------------------------------------------------
  // Execute stage
  // ------------------------------------------------------------------

  assign file_rs1 = {rdata1_1, rdata0_1};
  assign file_rs2 = {rdata1_2, rdata0_2};

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      e_imm[s]    = {{20{issued[s].inst.imm[11]}}, issued[s].inst.imm};
      e_rs1[s]    = issued[s].inst.op.rden1 ? forward(issued[s].inst.raddr1, file_rs1[s]) : '0;
      e_rs2[s]    = issued[s].inst.op.rden2 ? forward(issued[s].inst.raddr2, file_rs2[s]) : '0;
      e_result[s] = issued[s].inst.op.crden ? issued[s].cdata :
                    alu(issued[s].inst.op.alu_fn, e_rs1[s],
                        issued[s].inst.op.rden2 ? e_rs2[s] : e_imm[s], e_imm[s]);
      e_mem[s]    = issued[s].inst.op.load | issued[s].inst.op.store;
      e_status[s] = '{load: issued[s].inst.op.load, cwren: issued[s].inst.op.cwren,
                      waddr: issued[s].inst.waddr};
      m_status[s] = '{load: m_inst[s].op.load, cwren: m_inst[s].op.cwren,
                      waddr: m_inst[s].waddr};
    end
    mem_slot = e_mem[1];
    e_addr   = e_rs1[mem_slot] + e_imm[mem_slot];   // Word index.
  end

  // ------------------------------------------------------------------
  // Memory stage
  // ------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset) begin
      m_inst  <= '0;
      m_load  <= 1'b0;
      m_store <= 1'b0;
    end else begin
      m_inst  <= {issued[1].inst, issued[0].inst};
      m_load  <= issued[mem_slot].inst.op.load;
      m_store <= issued[mem_slot].inst.op.store;
    end
  end

  always_ff @(posedge clock) begin
    m_result <= e_result;
    m_rs1    <= e_rs1;
    m_addr   <= e_addr[DMEM_AW-1:0];
    m_wdata  <= e_rs2[mem_slot];
  end

  always_ff @(posedge clock) begin
    if (m_store) dmem[m_addr] <= m_wdata;
    if (m_load) load_data <= dmem[m_addr];
  end

  assign cwren  = m_inst[0].op.cwren | m_inst[1].op.cwren;
  assign caddr  = m_inst[0].op.cwren ? m_inst[0].caddr : m_inst[1].caddr;
  assign cwdata = m_inst[0].op.cwren ? m_rs1[0] : m_rs1[1];

  // ------------------------------------------------------------------
  // Writeback stage
  // ------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset) begin
      w_valid <= '0;
      w_load  <= '0;
    end else begin
      for (int s = 0; s < 2; s++) begin
        w_valid[s] <= m_inst[s].valid && m_inst[s].op.wren && (m_inst[s].waddr != 5'd0);
        w_load[s]  <= m_inst[s].op.load;
      end
    end
  end

  always_ff @(posedge clock) begin
    w_waddr  <= {m_inst[1].waddr, m_inst[0].waddr};
    w_result <= m_result;
  end

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      w_out[s] = '{valid: w_valid[s], waddr: w_waddr[s],
                   wdata: w_load[s] ? load_data : w_result[s]};
    end
  end

  assign retire0 = w_out[0];
  assign retire1 = w_out[1];

  a_single_mem_op: assert property (
    @(posedge clock) disable iff (!reset) !(e_mem[0] && e_mem[1])
  );

endmodule

// File: hdl/issue_pipe_top.sv
`timescale 1ns/1ns

module issue_pipe_top import issue_pkg::*; #(
  parameter int DMEM_DEPTH = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            flush,
  input  logic            pair_valid,
  input  instruction_type slot0,
  input  instruction_type slot1,
  output logic            hold,
  output retire_type      retire0,
  output retire_type      retire1
);

  instruction_type        calc0, calc1;
  logic                   split_hold;
  logic                   stall;
  register_read_type      read0, read1;
  csr_read_type           csr_rd;
  logic [31:0]            cdata;
  issued_type [1:0]       issued;
  stage_status_type [1:0] e_status, m_status;
  logic [31:0]            rdata0_1, rdata0_2, rdata1_1, rdata1_2;
  logic                   cwren;
  logic [11:0]            caddr;
  logic [31:0]            cwdata;

  pair_hazard_unit pair_hazard_unit_inst (
    .clock, .reset, .flush, .stall, .pair_valid, .slot0, .slot1,
    .calc0, .calc1, .split_hold
  );

  issue_stage issue_stage_inst (
    .clock, .reset, .flush, .calc0, .calc1, .split_hold, .e_status, .m_status,
    .cdata, .read0, .read1, .csr_rd, .issued, .stall, .hold
  );

  register_file register_file_inst (
    .clock, .reset, .read0, .read1, .rdata0_1, .rdata0_2, .rdata1_1, .rdata1_2,
    .write0(retire0), .write1(retire1)
  );

  csr_file csr_file_inst (
    .clock, .reset, .csr_rd, .cdata, .cwren, .caddr, .cwdata
  );

  execute_pipe #(
    .DMEM_DEPTH(DMEM_DEPTH)
  ) execute_pipe_inst (
    .clock, .reset, .issued, .rdata0_1, .rdata0_2, .rdata1_1, .rdata1_2,
    .e_status, .m_status, .cwren, .caddr, .cwdata, .retire0, .retire1
  );

endmodule

// File: tests/issue_pipe_tb.sv
`timescale 1ns/1ns

module issue_pipe_tb import issue_pkg::*; ();

  logic            clock = 1'b0;
  logic            reset;
  logic            flush;
  logic            pair_valid;
  instruction_type slot0;
  instruction_type slot1;
  logic            hold;
  retire_type      retire0;
  retire_type      retire1;

  retire_type      got_q[$];     // Retirements in order.
  logic [4:0]      exp_waddr[$];
  logic [31:0]     exp_wdata[$];
  int              errors;
  int              test_errors;
  int              tests_passed;
  int              tests_failed;
  int              test_index;

  always #5 clock = ~clock;

  issue_pipe_top #(
    .DMEM_DEPTH(16)
  ) issue_pipe_top_inst (
    .clock, .reset, .flush, .pair_valid, .slot0, .slot1, .hold, .retire0, .retire1
  );

  // Slot0 retires before slot1 in the same cycle.
  always @(negedge clock) begin
    if (reset) begin
      if (retire0.valid) got_q.push_back(retire0);
      if (retire1.valid) got_q.push_back(retire1);
    end
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  function automatic instruction_type make_inst(input logic [31:0] v, input logic [31:0] op,
                                                input logic [31:0] wa, input logic [31:0] r1,
                                                input logic [31:0] r2, input logic [31:0] imm,
                                                input logic [31:0] ca);
    instruction_type inst;
    inst        = init_instruction;
    inst.valid  = v[0];
    inst.op     = op[10:0];
    inst.waddr  = wa[4:0];
    inst.raddr1 = r1[4:0];
    inst.raddr2 = r2[4:0];
    inst.imm    = imm[11:0];
    inst.caddr  = ca[11:0];
    return inst;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // Keeps the pair on the inputs until it is accepted.
  task automatic present_pair(input logic fl, input instruction_type s0,
                              input instruction_type s1, output logic ok);
    int cycles;
    @(posedge clock);
    pair_valid <= 1'b1;
    flush      <= fl;
    slot0      <= s0;
    slot1      <= s1;
    cycles = 0;
    @(negedge clock);
    while (hold && cycles < 200) begin
      @(negedge clock);
      cycles++;
    end
    ok = !hold;
  endtask

  task automatic drive_idle();
    @(posedge clock);
    pair_valid <= 1'b0;
    flush      <= 1'b0;
    slot0      <= init_instruction;
    slot1      <= init_instruction;
  endtask

  task automatic finish_test(input string name, output logic ok);
    int cycles;
    int n;
    retire_type r;
    drive_idle();
    cycles = 0;
    while (got_q.size() < exp_waddr.size() && cycles < 200) begin
      @(negedge clock);
      cycles++;
    end
    ok = (got_q.size() >= exp_waddr.size());
    if (!ok) begin
      $display("test %s stalled with %0d of %0d retirements after 200 cycles",
               name, got_q.size(), exp_waddr.size());
    end else begin
      repeat (4) @(negedge clock);   // Pipeline drains.
      if (got_q.size() != exp_waddr.size()) begin
        $display("test %s retired %0d instructions where %0d were expected",
                 name, got_q.size(), exp_waddr.size());
        errors++;
        test_errors++;
      end
      n = exp_waddr.size();
      for (int i = 0; i < n && got_q.size() > 0; i++) begin
        r = got_q.pop_front();
        compare_value("retire.waddr", {27'd0, r.waddr}, {27'd0, exp_waddr[i]});
        compare_value("retire.wdata", r.wdata, exp_wdata[i]);
      end
      if (test_errors == 0) begin
        $display("test %s: passed", name);
        tests_passed++;
      end else begin
        $display("test %s: failed with %0d errors", name, test_errors);
        tests_failed++;
      end
    end
    got_q.delete();
    exp_waddr.delete();
    exp_wdata.delete();
    test_errors = 0;
  endtask

  // ------------------------------------------------------------------
  // File driven stimulus
  // ------------------------------------------------------------------

  initial begin
    int              fd;
    int              code;
    string           tok;
    string           line;
    string           name;
    logic [31:0]     fl, v, op, wa, r1, r2, imm, ca;
    instruction_type s0, s1;
    logic            ok;
    logic            aborted;

    reset        <= 1'b0;
    flush        <= 1'b0;
    pair_valid   <= 1'b0;
    slot0        <= init_instruction;
    slot1        <= init_instruction;
    errors       = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_index   = 1;
    aborted      = 1'b0;

    fd = $fopen("tests/issue_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tests/issue_input.txt");
      aborted = 1'b1;
    end
    repeat (2) @(posedge clock);
    reset <= 1'b1;

    while (!aborted && $fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) == "#") begin
        code = $fgets(line, fd);
      end else if (tok == "P") begin
        code = $fscanf(fd, "%h", fl);
        code = $fscanf(fd, "%h %h %h %h %h %h %h", v, op, wa, r1, r2, imm, ca);
        s0 = make_inst(v, op, wa, r1, r2, imm, ca);
        code = $fscanf(fd, "%h %h %h %h %h %h %h", v, op, wa, r1, r2, imm, ca);
        s1 = make_inst(v, op, wa, r1, r2, imm, ca);
        present_pair(fl[0], s0, s1, ok);
        if (!ok) begin
          $display("test %0d stalled with hold high for 200 cycles", test_index);
          aborted = 1'b1;
        end
      end else if (tok == "E") begin
        code = $fscanf(fd, "%h %h", wa, v);
        exp_waddr.push_back(wa[4:0]);
        exp_wdata.push_back(v);
      end else if (tok == "T") begin
        code = $fscanf(fd, "%s", name);
        finish_test(name, ok);
        if (!ok) aborted = 1'b1;
        test_index++;
      end else begin
        $display("unknown line type %s in the stimulus file", tok);
        aborted = 1'b1;
      end
    end
    if (fd != 0) $fclose(fd);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && !aborted && tests_failed == 0 && tests_passed > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: issue_pipe.f
hdl/issue_pkg.sv
hdl/pair_hazard_unit.sv
hdl/issue_stage.sv
hdl/register_file.sv
hdl/csr_file.sv
hdl/execute_pipe.sv
hdl/issue_pipe_top.sv
tests/issue_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue pipeline testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module issue_pipe_tb \
  -f issue_pipe.f -o issue_pipe_sim > build.log 2>&1 \
  && ./obj_dir/issue_pipe_sim > sim.log 2>&1 \
  || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log
! grep -q "TEST RESULT: FAIL" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tests/issue_input.txt
# P flush, then per slot: valid op waddr raddr1 raddr2 imm caddr (all hex)
# E waddr wdata in retirement order; T name closes a test
P 0 1 127 01 00 00 005 000 1 127 02 00 00 00c 000
P 0 1 720 03 01 02 000 000 1 721 04 02 01 000 000
P 0 1 724 05 01 02 000 000 1 725 06 02 01 000 000
P 0 1 726 07 01 02 000 000 1 520 08 04 00 fff 000
E 01 00000005
E 02 0000000c
E 03 00000011
E 04 00000007
E 05 00000009
E 06 00000180
E 07 00000001
E 08 00000006
T alu_pairs
# slot1 depends on slot0
P 0 1 520 09 01 00 010 000 1 720 0a 09 02 000 000
P 0 1 723 0b 01 02 000 000 1 722 0c 0b 02 000 000
E 09 00000015
E 0a 00000021
E 0b 0000000d
E 0c 0000000c
T split_pair
# store x3 to word 3, then load it and use it
P 0 1 640 00 00 03 003 000 1 127 0d 00 00 7ab 000
P 0 1 580 0e 00 00 003 000 1 720 0f 0e 01 000 000
E 0d 000007ab
E 0e 00000011
E 0f 00000016
T load_use
# csrrw mscratch with x2, then read mscratch
P 0 1 518 10 02 00 000 340 1 110 11 00 00 000 340
E 10 00000000
E 11 0000000c
T csr_write_read
P 1 1 127 12 00 00 0aa 000 1 127 13 00 00 0bb 000
P 0 1 127 14 00 00 0cc 000 1 127 12 00 00 055 000
E 14 000000cc
E 12 00000055
T flush_pair
P 0 1 127 00 00 00 123 000 1 127 16 00 00 044 000
P 0 1 520 17 00 00 001 000 1 723 18 00 01 000 000
E 16 00000044
E 17 00000001
E 18 00000005
T zero_register
